// File: sources.f
hdl/uart_str_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/string_framer.sv
hdl/string_deframer.sv
hdl/apb_string_regs.sv
hdl/uart_string_handle.sv
tests/tb_clock.sv
tests/uart_string_properties.sv
tests/uart_string_checker.sv
tests/uart_string_tb.sv

// File: tests/uart_string_tb.sv
// Top-level testbench of the string link. Loads strings over APB and sends
// them through a txd to rxd loopback, or drives the receive line from a raw
// byte sender. Expected results go to the checker module.
`timescale 1ns/1ns

module uart_string_tb;

	// one byte time plus turnaround, used to size the watchdog
	localparam int cycles_per_byte = 170;

	logic                    sys_clk;
	logic                    sys_rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	uart_str_pkg::apb_addr_t paddr;
	uart_str_pkg::apb_data_t pwdata;
	uart_str_pkg::apb_data_t prdata;
	logic                    irq;
	logic                    uart_rxd;
	logic                    uart_txd;
	logic                    use_raw;
	logic                    raw_line;
	logic                    run_done;
	int                      errors;
	int                      checks;
	int                      expected_frames;
	int                      budget_bytes;
	int                      rand_lens [6];
	logic [511:0]            msg;
	int                      msg_len;

	tb_clock clock_i (.sys_clk(sys_clk));

	uart_string_handle uart_string_handle_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.irq(irq), .uart_rxd(uart_rxd), .uart_txd(uart_txd)
	);

	uart_string_checker checker_i (
		.sys_clk(sys_clk), .irq(irq), .run_done(run_done),
		.assert_fails(uart_string_handle_i.props_i.assert_fails),
		.errors(errors), .checks(checks)
	);

	// the raw sender takes over the receive line when use_raw is set
	assign uart_rxd = use_raw ? raw_line : uart_txd;

	// -------------------------------------------------
	// APB master
	// -------------------------------------------------
	task automatic apb_write(input uart_str_pkg::apb_addr_t addr,
		input uart_str_pkg::apb_data_t data);
		@(posedge sys_clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		@(posedge sys_clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input uart_str_pkg::apb_addr_t addr,
		output uart_str_pkg::apb_data_t data);
		@(posedge sys_clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		@(negedge sys_clk);
		data = prdata;
		@(posedge sys_clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// expected receive result for a content string of n bytes
	function automatic void expected_rx(input logic [511:0] content, input int n,
		output logic [255:0] data, output uart_str_pkg::str_len_t len, output logic ovf);
		data = '0;
		for (int i = 0; i < n && i < uart_str_pkg::max_len; i++) begin
			data[8*i +: 8] = content[8*i +: 8];
		end
		len = (n > uart_str_pkg::max_len) ? uart_str_pkg::max_len : n;
		ovf = (n > uart_str_pkg::max_len);
	endfunction

	function automatic void make_random(input int n);
		uart_str_pkg::byte_t b;
		msg     = '0;
		msg_len = n;
		for (int i = 0; i < n; i++) begin
			b = uart_str_pkg::byte_t'(8'h21 + $urandom % 94);
			// a mark may not end the content or follow another mark
			if (b == uart_str_pkg::frame_mark &&
				(i == n - 1 || (i > 0 && msg[8*(i-1) +: 8] == uart_str_pkg::frame_mark))) begin
				b = 8'h61;
			end
			msg[8*i +: 8] = b;
		end
	endfunction

	function automatic void set_text(input string s);
		msg     = '0;
		msg_len = s.len();
		for (int i = 0; i < s.len(); i++) begin
			msg[8*i +: 8] = s[i];
		end
	endfunction

	task automatic queue_expected();
		logic [255:0]           data;
		uart_str_pkg::str_len_t len;
		logic                   ovf;
		expected_rx(msg, msg_len, data, len, ovf);
		checker_i.expect_frame(data, len, ovf);
		expected_frames++;
	endtask

	// loads msg into the transmit buffer, starts it and waits for the check
	task automatic send_looped(input logic restart_busy);
		apb_write(uart_str_pkg::addr_tx_len, msg_len);
		for (int w = 0; w < (msg_len + 3) / 4; w++) begin
			apb_write(uart_str_pkg::apb_addr_t'(uart_str_pkg::addr_tx_data + 4 * w),
				msg[32*w +: 32]);
		end
		queue_expected();
		apb_write(uart_str_pkg::addr_ctrl, 32'h1);
		if (restart_busy) begin
			apb_write(uart_str_pkg::addr_ctrl, 32'h1);
		end
		wait (checks == expected_frames);
	endtask

	// -------------------------------------------------
	// raw serial sender, 8N1 at the package bit time
	// -------------------------------------------------
	task automatic hold_line_bit(input logic v);
		@(posedge sys_clk);
		#1;
		raw_line = v;
		repeat (uart_str_pkg::clks_per_bit - 1) @(posedge sys_clk);
	endtask

	task automatic send_raw_byte(input uart_str_pkg::byte_t b);
		hold_line_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			hold_line_bit(b[i]);
		end
		hold_line_bit(1'b1);
	endtask

	task automatic send_raw_frame();
		queue_expected();
		send_raw_byte(uart_str_pkg::frame_mark);
		send_raw_byte(uart_str_pkg::frame_mark);
		for (int i = 0; i < msg_len; i++) begin
			send_raw_byte(msg[8*i +: 8]);
		end
		send_raw_byte(uart_str_pkg::frame_mark);
		send_raw_byte(uart_str_pkg::frame_mark);
		wait (checks == expected_frames);
	endtask

	// -------------------------------------------------
	// stimulus
	// -------------------------------------------------
	initial begin
		sys_rst_n       = 1'b0;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		use_raw         = 1'b0;
		raw_line        = 1'b1;
		run_done        = 1'b0;
		expected_frames = 0;
		msg             = '0;
		msg_len         = 0;
		void'($urandom(97660));
		rand_lens[0] = 1;
		rand_lens[1] = 32;
		for (int i = 2; i < 6; i++) begin
			rand_lens[i] = 1 + $urandom % 32;
		end
		// fixed cases plus a quiet window of one 8-byte frame after the restart test
		budget_bytes = 13 + 13 + 44 + 12 + 12;
		for (int i = 0; i < 6; i++) begin
			budget_bytes += rand_lens[i] + 4;
		end
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		for (int i = 0; i < 6; i++) begin
			make_random(rand_lens[i]);
			send_looped(1'b0);
		end
		set_text("ab&cd&e&f");
		send_looped(1'b0);

		// junk and a false opening ahead of the frame
		use_raw = 1'b1;
		send_raw_byte("x");
		send_raw_byte("y");
		send_raw_byte(uart_str_pkg::frame_mark);
		send_raw_byte("q");
		set_text("hello");
		send_raw_frame();
		make_random(40);
		send_raw_frame();
		use_raw = 1'b0;

		// a restart while busy and a start with zero length add no frame
		make_random(8);
		send_looped(1'b1);
		apb_write(uart_str_pkg::addr_tx_len, 32'h0);
		apb_write(uart_str_pkg::addr_ctrl, 32'h1);
		checker_i.check_tx_idle();
		repeat (12 * cycles_per_byte) @(posedge sys_clk);

		run_done = 1'b1;
		#1;
		if (errors == 0 && uart_string_handle_i.props_i.assert_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (budget_bytes > 0);
		repeat (2 * budget_bytes * cycles_per_byte) @(posedge sys_clk);
		$display("watchdog expired before all strings were received and checked");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: tests/uart_string_checker.sv
// Watches irq and reads each received string back over APB through the
// bus tasks of the testbench, then compares it with the queued expected
// result and clears the status. Prints the counts when the run ends.
`timescale 1ns/1ns

module uart_string_checker (
	input  logic sys_clk,
	input  logic irq,
	input  logic run_done,
	input  int   assert_fails,
	output int   errors,
	output int   checks
);

	typedef struct packed {
		logic [8*uart_str_pkg::max_len-1:0] data;
		uart_str_pkg::str_len_t             len;
		logic                               overflow;
	} exp_rx_t;

	exp_rx_t exp_q [$];
	logic    irq_seen;

	task automatic expect_frame(input logic [8*uart_str_pkg::max_len-1:0] data,
		input uart_str_pkg::str_len_t len, input logic overflow);
		exp_rx_t e;
		e.data     = data;
		e.len      = len;
		e.overflow = overflow;
		exp_q.push_back(e);
	endtask

	task automatic compare_field(input string name, input int got, input int want);
		if (got != want) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s read 0x%0h, expected 0x%0h",
				$time, name, got, want);
		end
	endtask

	// a refused start leaves the framer idle
	task automatic check_tx_idle();
		uart_str_pkg::apb_data_t st;
		uart_string_tb.apb_read(uart_str_pkg::addr_status, st);
		compare_field("tx_busy", st[0], 0);
	endtask

	// -------------------------------------------------
	// one received string
	// -------------------------------------------------
	task automatic check_frame();
		exp_rx_t                 e;
		uart_str_pkg::apb_data_t st;
		uart_str_pkg::apb_data_t word;
		logic                    matched;
		matched = 1'b0;
		if (exp_q.size() == 0) begin
			errors++;
			$display("%0t ns: irq raised although no string was sent", $time);
		end else begin
			matched = 1'b1;
			e = exp_q.pop_front();
			uart_string_tb.apb_read(uart_str_pkg::addr_status, st);
			compare_field("rx_ready", st[1], 1);
			compare_field("rx_overflow", st[2], e.overflow);
			compare_field("rx_len", st[13:8], e.len);
			for (int w = 0; w < uart_str_pkg::max_len / 4; w++) begin
				uart_string_tb.apb_read(
					uart_str_pkg::apb_addr_t'(uart_str_pkg::addr_rx_data + 4 * w), word);
				for (int k = 0; k < 4; k++) begin
					// bytes past the length are stale and not compared
					if (4 * w + k < e.len) begin
						compare_field($sformatf("rx_data byte %0d", 4 * w + k),
							word[8*k +: 8], e.data[8*(4*w+k) +: 8]);
					end
				end
			end
		end
		// clear and confirm that irq and rx_ready drop
		uart_string_tb.apb_write(uart_str_pkg::addr_status, 32'h2);
		uart_string_tb.apb_read(uart_str_pkg::addr_status, st);
		compare_field("rx_ready after clear", st[1], 0);
		compare_field("rx_overflow after clear", st[2], 0);
		compare_field("irq after clear", irq, 0);
		if (matched) begin
			checks++;
		end
	endtask

	initial begin
		errors   = 0;
		checks   = 0;
		irq_seen = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (irq && !irq_seen) begin
				check_frame();
			end
			irq_seen = irq;
		end
	end

	initial begin
		@(posedge run_done);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected strings were never received", exp_q.size());
		end
		$display("strings checked: %0d  errors: %0d  assertion failures: %0d",
			checks, errors, assert_fails);
	end

endmodule

// File: tests/uart_string_properties.sv
// Concurrent assertions on the serializer handshake, the idle transmit line
// and the receive completion pulse. Bound into the top level of the link.
`timescale 1ns/1ns

module uart_string_properties (
	input logic                    sys_clk,
	input logic                    sys_rst_n,
	input logic                    byte_req,
	input logic                    byte_done,
	input logic                    tx_busy,
	input logic                    uart_txd,
	input uart_str_pkg::rx_frame_t frame
);

	int   assert_fails = 0;
	logic ser_busy;

	// a byte is in flight from its request up to its done pulse
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ser_busy <= 1'b0;
		end else if (byte_req) begin
			ser_busy <= 1'b1;
		end else if (byte_done) begin
			ser_busy <= 1'b0;
		end
	end

	req_while_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		ser_busy |-> !byte_req)
	else begin
		$error("byte request issued while the serializer is busy");
		assert_fails++;
	end

	idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_txd)
	else begin
		$error("transmit line low while the framer is idle");
		assert_fails++;
	end

	done_single_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		frame.done |=> !frame.done)
	else begin
		$error("receive done pulse longer than one cycle");
		assert_fails++;
	end

endmodule

bind uart_string_handle uart_string_properties props_i (
	.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
	.byte_req(byte_req), .byte_done(byte_done),
	.tx_busy(tx_busy), .uart_txd(uart_txd), .frame(frame)
);

// File: tests/tb_clock.sv
// Free-running system clock for the testbench, 8 ns period
`timescale 1ns/1ns

module tb_clock (
	output logic sys_clk
);

	localparam int half_period = 4;

	initial begin
		sys_clk = 1'b0;
		forever #half_period sys_clk = ~sys_clk;
	end

endmodule

// File: hdl/uart_string_handle.sv
// Top level of the string link. The host talks APB to the register block,
// the framer and deframer sit between the buffers and the UART byte pair.
`timescale 1ns/1ns

module uart_string_handle (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  uart_str_pkg::apb_addr_t paddr,
	input  uart_str_pkg::apb_data_t pwdata,
	output uart_str_pkg::apb_data_t prdata,
	output logic                    irq,
	input  logic                    uart_rxd,
	output logic                    uart_txd
);

	uart_str_pkg::tx_cmd_t   cmd;
	logic                    tx_busy;
	uart_str_pkg::byte_idx_t tx_rd_idx;
	uart_str_pkg::byte_t     tx_rd_byte;
	logic                    byte_req;
	uart_str_pkg::byte_t     tx_byte;
	logic                    byte_done;
	logic                    rx_vld;
	uart_str_pkg::byte_t     rx_byte;
	uart_str_pkg::rx_wr_t    wr;
	uart_str_pkg::rx_frame_t frame;

	apb_string_regs regs_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.cmd(cmd), .tx_busy(tx_busy),
		.tx_rd_idx(tx_rd_idx), .tx_rd_byte(tx_rd_byte),
		.wr(wr), .frame(frame), .irq(irq)
	);

	string_framer framer_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cmd(cmd), .tx_busy(tx_busy),
		.tx_rd_idx(tx_rd_idx), .tx_rd_byte(tx_rd_byte),
		.byte_req(byte_req), .byte_data(tx_byte), .byte_done(byte_done)
	);

	uart_tx tx_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.byte_req(byte_req), .byte_data(tx_byte),
		.byte_done(byte_done), .txd(uart_txd)
	);

	uart_rx rx_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rxd(uart_rxd), .byte_vld(rx_vld), .byte_data(rx_byte)
	);

	string_deframer deframer_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.byte_vld(rx_vld), .byte_data(rx_byte),
		.wr(wr), .frame(frame)
	);

endmodule

// File: hdl/apb_string_regs.sv
// APB register block with no wait states. Holds the transmit length, the
// transmit and receive string buffers and the sticky receive status, and
// issues the start command to the framer.
`timescale 1ns/1ns

module apb_string_regs (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  uart_str_pkg::apb_addr_t paddr,
	input  uart_str_pkg::apb_data_t pwdata,
	output uart_str_pkg::apb_data_t prdata,
	output uart_str_pkg::tx_cmd_t   cmd,
	input  logic                    tx_busy,
	input  uart_str_pkg::byte_idx_t tx_rd_idx,
	output uart_str_pkg::byte_t     tx_rd_byte,
	input  uart_str_pkg::rx_wr_t    wr,
	input  uart_str_pkg::rx_frame_t frame,
	output logic                    irq
);

	logic                   wr_acc;
	logic                   tx_win;
	logic                   rx_win;
	logic [2:0]             word_sel;
	uart_str_pkg::str_len_t tx_len;
	uart_str_pkg::str_len_t rx_len;
	logic                   rx_ready;
	logic                   rx_ovf;
	uart_str_pkg::byte_t    tx_buf [uart_str_pkg::max_len];
	uart_str_pkg::byte_t    rx_buf [uart_str_pkg::max_len];

	assign wr_acc   = psel & penable & pwrite;
	assign tx_win   = (paddr[7:5] == uart_str_pkg::addr_tx_data[7:5]);
	assign rx_win   = (paddr[7:5] == uart_str_pkg::addr_rx_data[7:5]);
	assign word_sel = paddr[4:2];

	// -------------------------------------------------
	// control and status
	// -------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cmd      <= '0;
			tx_len   <= '0;
			rx_len   <= '0;
			rx_ready <= 1'b0;
			rx_ovf   <= 1'b0;
		end else begin
			cmd.start <= 1'b0;
			// start while busy or with an empty string is ignored
			if (wr_acc && paddr == uart_str_pkg::addr_ctrl && pwdata[0] &&
				!tx_busy && tx_len != '0) begin
				cmd.start <= 1'b1;
				cmd.len   <= tx_len;
			end
			if (wr_acc && paddr == uart_str_pkg::addr_tx_len) begin
				tx_len <= (pwdata > uart_str_pkg::apb_data_t'(uart_str_pkg::max_len)) ?
					uart_str_pkg::str_len_t'(uart_str_pkg::max_len) :
					uart_str_pkg::str_len_t'(pwdata);
			end
			if (wr_acc && paddr == uart_str_pkg::addr_status && pwdata[1]) begin
				rx_ready <= 1'b0;
				rx_ovf   <= 1'b0;
			end
			// a completing string wins over a clear in the same cycle
			if (frame.done) begin
				rx_len   <= frame.len;
				rx_ready <= 1'b1;
				rx_ovf   <= rx_ovf | frame.overflow;
			end
		end
	end

	// -------------------------------------------------
	// string buffers
	// -------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (wr_acc && tx_win) begin
			for (int k = 0; k < 4; k++) begin
				tx_buf[{word_sel, 2'(k)}] <= pwdata[8*k +: 8];
			end
		end
		if (wr.en) begin
			rx_buf[wr.idx] <= wr.data;
		end
	end

	assign tx_rd_byte = tx_buf[tx_rd_idx];

	// read mux, little-endian bytes within each data word
	always_comb begin
		prdata = '0;
		if (tx_win) begin
			prdata = {tx_buf[{word_sel, 2'd3}], tx_buf[{word_sel, 2'd2}],
				tx_buf[{word_sel, 2'd1}], tx_buf[{word_sel, 2'd0}]};
		end else if (rx_win) begin
			prdata = {rx_buf[{word_sel, 2'd3}], rx_buf[{word_sel, 2'd2}],
				rx_buf[{word_sel, 2'd1}], rx_buf[{word_sel, 2'd0}]};
		end else if (paddr == uart_str_pkg::addr_status) begin
			prdata = {18'd0, rx_len, 5'd0, rx_ovf, rx_ready, tx_busy};
		end else if (paddr == uart_str_pkg::addr_tx_len) begin
			prdata = {26'd0, tx_len};
		end
	end

	assign irq = rx_ready;

endmodule

// File: hdl/string_deframer.sv
// Receive side framing. Hunts for "&&", stores the content bytes into the
// receive buffer and reports the string length at the closing "&&".
// A lone "&" inside the content is kept, written one cycle ahead of the
// byte that follows it.
`timescale 1ns/1ns

module string_deframer (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    byte_vld,
	input  uart_str_pkg::byte_t     byte_data,
	output uart_str_pkg::rx_wr_t    wr,
	output uart_str_pkg::rx_frame_t frame
);

	uart_str_pkg::rx_state_e state;
	uart_str_pkg::str_len_t  len;
	logic                    ovf;
	logic                    is_mark;
	logic                    hold_vld;
	uart_str_pkg::byte_t     hold_data;
	logic                    st_en;
	uart_str_pkg::byte_t     st_data;
	logic                    open_hit;
	logic                    close_hit;
	logic                    lone_mark;

	assign is_mark   = (byte_data == uart_str_pkg::frame_mark);
	assign open_hit  = byte_vld && is_mark && (state == uart_str_pkg::rx_open);
	assign close_hit = byte_vld && is_mark && (state == uart_str_pkg::rx_close);
	assign lone_mark = byte_vld && !is_mark && (state == uart_str_pkg::rx_close);

	// -------------------------------------------------
	// frame FSM
	// -------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_str_pkg::rx_hunt;
		end else if (byte_vld) begin
			case (state)
				uart_str_pkg::rx_hunt:    if (is_mark) state <= uart_str_pkg::rx_open;
				uart_str_pkg::rx_open:
					state <= is_mark ? uart_str_pkg::rx_content : uart_str_pkg::rx_hunt;
				uart_str_pkg::rx_content: if (is_mark) state <= uart_str_pkg::rx_close;
				uart_str_pkg::rx_close:
					state <= is_mark ? uart_str_pkg::rx_hunt : uart_str_pkg::rx_content;
				default: state <= uart_str_pkg::rx_hunt;
			endcase
		end
	end

	// byte after a lone mark waits one cycle for its own buffer write
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			hold_vld <= 1'b0;
		end else begin
			hold_vld <= lone_mark;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (lone_mark) begin
			hold_data <= byte_data;
		end
	end

	// -------------------------------------------------
	// store selection
	// -------------------------------------------------
	always_comb begin
		st_en   = 1'b0;
		st_data = byte_data;
		if (hold_vld) begin
			st_en   = 1'b1;
			st_data = hold_data;
		end else if (byte_vld && !is_mark && state == uart_str_pkg::rx_content) begin
			st_en = 1'b1;
		end else if (lone_mark) begin
			st_en   = 1'b1;
			st_data = uart_str_pkg::frame_mark;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			len   <= '0;
			ovf   <= 1'b0;
			wr    <= '0;
			frame <= '0;
		end else begin
			wr.en      <= 1'b0;
			frame.done <= 1'b0;
			if (open_hit) begin
				len <= '0;
				ovf <= 1'b0;
			end else if (st_en) begin
				// full buffer drops the byte and the length stays at max_len
				if (len < uart_str_pkg::str_len_t'(uart_str_pkg::max_len)) begin
					wr.en   <= 1'b1;
					wr.idx  <= uart_str_pkg::byte_idx_t'(len);
					wr.data <= st_data;
					len     <= len + 1'b1;
				end else begin
					ovf <= 1'b1;
				end
			end
			if (close_hit) begin
				frame.done     <= 1'b1;
				frame.len      <= len;
				frame.overflow <= ovf;
			end
		end
	end

endmodule

// File: hdl/string_framer.sv
// Transmit side framing. On a start command it sends "&&", the content bytes
// in index order from the transmit buffer, then "&&", one byte request at a
// time, each issued the cycle after the previous byte_done.
`timescale 1ns/1ns

module string_framer (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  uart_str_pkg::tx_cmd_t   cmd,
	output logic                    tx_busy,
	output uart_str_pkg::byte_idx_t tx_rd_idx,
	input  uart_str_pkg::byte_t     tx_rd_byte,
	output logic                    byte_req,
	output uart_str_pkg::byte_t     byte_data,
	input  logic                    byte_done
);

	uart_str_pkg::tx_state_e state;
	uart_str_pkg::str_len_t  len_q;
	// number of content bytes already handed to the serializer
	uart_str_pkg::str_len_t  cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= uart_str_pkg::tx_idle;
			len_q     <= '0;
			cnt       <= '0;
			byte_req  <= 1'b0;
			byte_data <= '0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				uart_str_pkg::tx_idle: begin
					if (cmd.start) begin
						len_q     <= cmd.len;
						cnt       <= '0;
						byte_req  <= 1'b1;
						byte_data <= uart_str_pkg::frame_mark;
						state     <= uart_str_pkg::tx_mark1;
					end
				end
				uart_str_pkg::tx_mark1: begin
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= uart_str_pkg::frame_mark;
						state     <= uart_str_pkg::tx_mark2;
					end
				end
				uart_str_pkg::tx_mark2: begin
					// the register block only starts with a non-zero length
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= tx_rd_byte;
						cnt       <= cnt + 1'b1;
						state     <= uart_str_pkg::tx_content;
					end
				end
				uart_str_pkg::tx_content: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (cnt == len_q) begin
							byte_data <= uart_str_pkg::frame_mark;
							state     <= uart_str_pkg::tx_mark3;
						end else begin
							byte_data <= tx_rd_byte;
							cnt       <= cnt + 1'b1;
						end
					end
				end
				uart_str_pkg::tx_mark3: begin
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= uart_str_pkg::frame_mark;
						state     <= uart_str_pkg::tx_mark4;
					end
				end
				uart_str_pkg::tx_mark4: begin
					if (byte_done) begin
						state <= uart_str_pkg::tx_idle;
					end
				end
				default: state <= uart_str_pkg::tx_idle;
			endcase
		end
	end

	assign tx_busy   = (state != uart_str_pkg::tx_idle);
	assign tx_rd_idx = uart_str_pkg::byte_idx_t'(cnt);

endmodule

// File: hdl/uart_rx.sv
// 8N1 byte deserializer. The line is synchronized by two flops, the start
// bit is checked again at half a bit time and each later bit is sampled at
// mid-bit. A byte whose stop bit reads low is dropped.
`timescale 1ns/1ns

module uart_rx (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                rxd,
	output logic                byte_vld,
	output uart_str_pkg::byte_t byte_data
);

	logic                   rxd_meta;
	logic                   rxd_sync;
	logic                   rxd_prev;
	logic                   start_edge;
	logic                   busy;
	uart_str_pkg::div_cnt_t div_cnt;
	uart_str_pkg::bit_cnt_t bit_cnt;
	uart_str_pkg::byte_t    shreg;

	// -------------------------------------------------
	// synchronizer and edge detect
	// -------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign start_edge = rxd_prev & ~rxd_sync;

	// -------------------------------------------------
	// bit timing and sampling
	// -------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			byte_vld <= 1'b0;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			shreg    <= '0;
		end else begin
			byte_vld <= 1'b0;
			if (!busy) begin
				// preload half a bit so the first sample lands mid start bit
				if (start_edge) begin
					busy    <= 1'b1;
					div_cnt <= uart_str_pkg::div_cnt_t'(uart_str_pkg::clks_per_bit / 2);
					bit_cnt <= '0;
				end
			end else if (div_cnt == uart_str_pkg::div_cnt_t'(uart_str_pkg::clks_per_bit - 1)) begin
				div_cnt <= '0;
				if (bit_cnt == '0) begin
					// a glitch that is high again at mid start bit is no start
					if (rxd_sync) begin
						busy <= 1'b0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end else if (bit_cnt == uart_str_pkg::bit_cnt_t'(uart_str_pkg::frame_bits - 1)) begin
					busy     <= 1'b0;
					byte_vld <= rxd_sync;
				end else begin
					shreg   <= {rxd_sync, shreg[7:1]};
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	assign byte_data = shreg;

endmodule

// File: hdl/uart_tx.sv
// 8N1 byte serializer. A one-cycle byte_req loads the byte, the start bit
// goes out the next cycle and byte_done pulses once the stop bit ends.
`timescale 1ns/1ns

module uart_tx (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                byte_req,
	input  uart_str_pkg::byte_t byte_data,
	output logic                byte_done,
	output logic                txd
);

	logic                                busy;
	logic [uart_str_pkg::frame_bits-1:0] shreg;
	uart_str_pkg::div_cnt_t              div_cnt;
	uart_str_pkg::bit_cnt_t              bit_cnt;

	// shreg holds stop, data and start bits, and bit 0 is on the line
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			byte_done <= 1'b0;
			shreg     <= '1;
			div_cnt   <= '0;
			bit_cnt   <= '0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				// a request while busy is never made by the framer
				if (byte_req) begin
					busy    <= 1'b1;
					shreg   <= {1'b1, byte_data, 1'b0};
					div_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (div_cnt == uart_str_pkg::div_cnt_t'(uart_str_pkg::clks_per_bit - 1)) begin
				div_cnt <= '0;
				if (bit_cnt == uart_str_pkg::bit_cnt_t'(uart_str_pkg::frame_bits - 1)) begin
					busy      <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					shreg   <= {1'b1, shreg[uart_str_pkg::frame_bits-1:1]};
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// idle line is high
	assign txd = busy ? shreg[0] : 1'b1;

endmodule

// File: hdl/uart_str_pkg.sv
// Shared widths, register map, frame marker, FSM encodings and the packed
// structs used between the string framing blocks and the APB register block.
// Referenced by scoped names only.
package uart_str_pkg;

	// -------------------------------------------------
	// sizes and line timing
	// -------------------------------------------------
	localparam int max_len      = 32;
	localparam int clks_per_bit = 16;
	localparam int frame_bits   = 10;
	localparam int div_w        = $clog2(clks_per_bit);

	typedef logic [7:0]       byte_t;
	typedef logic [5:0]       str_len_t;
	typedef logic [4:0]       byte_idx_t;
	typedef logic [7:0]       apb_addr_t;
	typedef logic [31:0]      apb_data_t;
	typedef logic [div_w-1:0] div_cnt_t;
	typedef logic [3:0]       bit_cnt_t;

	// the "&" character that opens and closes every string
	localparam byte_t frame_mark = 8'h26;

	// -------------------------------------------------
	// register map
	// -------------------------------------------------
	localparam apb_addr_t addr_ctrl    = 8'h00;
	localparam apb_addr_t addr_status  = 8'h04;
	localparam apb_addr_t addr_tx_len  = 8'h08;
	localparam apb_addr_t addr_tx_data = 8'h40;
	localparam apb_addr_t addr_rx_data = 8'h80;

	typedef enum logic [2:0] {
		tx_idle, tx_mark1, tx_mark2, tx_content, tx_mark3, tx_mark4
	} tx_state_e;

	typedef enum logic [1:0] {
		rx_hunt, rx_open, rx_content, rx_close
	} rx_state_e;

	typedef struct packed {
		logic      en;
		byte_idx_t idx;
		byte_t     data;
	} rx_wr_t;

	typedef struct packed {
		logic     done;
		str_len_t len;
		logic     overflow;
	} rx_frame_t;

	typedef struct packed {
		logic     start;
		str_len_t len;
	} tx_cmd_t;

endpackage
